/* include/fc_xcvr_config.svh */
`ifndef FC_XCVR_CONFIG_SVH
`define FC_XCVR_CONFIG_SVH

// lane count, 1 to 8 supported
`define FC_LANES 4

// flops in the status word synchronizer
`define FC_SYNC_STAGES 3

// management address map
// bit 9 selects the vendor phy bus, below that the local registers
`define FC_PHY_SEL_BIT 9

// one 32-bit register per word, status at +0 and sticky at +4
`define FC_REG_SEL_BIT 2

// lane index starts above the register select bit
// widen FC_LANE_SEL_BITS to 3 when FC_LANES goes above 4
`define FC_LANE_SEL_LSB 3
`define FC_LANE_SEL_BITS 2

`endif

/* rtl/fc_xcvr_pkg.sv */
package fc_xcvr_pkg;

  // four 9-bit groups, byte n at [9n+7:9n], k flag at 9n+8
  // byte 0 is sent first
  typedef logic [35:0] char_word_t;

  // phy parallel side, byte 0 in the low byte
  typedef logic [31:0] phy_word_t;

  // one bit per byte lane of the phy word
  typedef logic [3:0] lane_flags_t;

  // management bus fields
  typedef logic [9:0]  mm_addr_t;   // master side address
  typedef logic [8:0]  phy_addr_t;  // vendor phy mgmt address
  typedef logic [31:0] mm_data_t;   // read and write data

  // live status readback word
  typedef struct packed {
    logic [14:0] rsvd;            // reads as zero
    logic        pll_locked;      // bit 16
    lane_flags_t disperr;         // bits 15:12
    lane_flags_t errdetect;       // bits 11:8
    lane_flags_t patterndetect;   // bits 7:4
    lane_flags_t syncstatus;      // bits 3:0
  } status_word_t;

  // sticky error register
  //   3:0  disperr seen
  //   7:4  errdetect seen
  //   8    pll_locked fell
  //   9    sync lost after full sync
  typedef struct packed {
    logic [21:0] rsvd;
    logic        sync_lost;
    logic        pll_lost;
    lane_flags_t errdetect;
    lane_flags_t disperr;
  } sticky_word_t;

endpackage

/* rtl/fc_mgmt_decode.sv */
`include "fc_xcvr_config.svh"

module fc_mgmt_decode (
  input  logic                                  mgmt_clk,
  input  logic                                  reset,
  input  fc_xcvr_pkg::mm_addr_t                 mm_address,
  input  logic                                  mm_read,
  input  logic                                  mm_write,
  input  fc_xcvr_pkg::mm_data_t                 mm_writedata,
  input  logic                                  phy_mgmt_waitrequest,
  output logic                                  mm_waitrequest,
  output fc_xcvr_pkg::phy_addr_t                phy_mgmt_address,
  output logic                                  phy_mgmt_read,
  output logic                                  phy_mgmt_write,
  output fc_xcvr_pkg::mm_data_t                 phy_mgmt_writedata,
  output logic                                  local_sel,
  output fc_xcvr_pkg::mm_data_t [`FC_LANES-1:0] lane_clear
);

  localparam int idx_w = `FC_PHY_SEL_BIT - `FC_LANE_SEL_LSB;  // address bits 8 down to lsb

  logic             phy_sel;    // access goes to the vendor phy
  logic [idx_w-1:0] lane_idx;   // full lane field, upper bits included
  logic             reg_sel;    // 1 sticky, 0 live status
  logic             lane_ok;    // lane exists
  logic             stall_q;    // last cycle was a write held by the phy
  logic             clear_wr;   // local write to a sticky register

  assign phy_sel   = mm_address[`FC_PHY_SEL_BIT];
  assign local_sel = ~phy_sel;
  assign lane_idx  = mm_address[`FC_PHY_SEL_BIT-1:`FC_LANE_SEL_LSB];
  assign reg_sel   = mm_address[`FC_REG_SEL_BIT];
  assign lane_ok   = int'(lane_idx) < `FC_LANES;

  // passthrough, nothing leaks to the phy on a local access
  assign phy_mgmt_read      = phy_sel & mm_read;
  assign phy_mgmt_write     = phy_sel & mm_write;
  assign phy_mgmt_address   = phy_sel ? mm_address[`FC_PHY_SEL_BIT-1:0] : '0;
  assign phy_mgmt_writedata = phy_sel ? mm_writedata : '0;

  // local registers answer at once
  assign mm_waitrequest = phy_sel & phy_mgmt_waitrequest;

  // A write the phy stalled is still the same access in the cycle after
  // the stall, even if the master lets the address wander.  Only the
  // first cycle of a fresh write is allowed to clear sticky bits.
  always_ff @(posedge mgmt_clk) begin
    if (reset) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= mm_write & mm_waitrequest;  // held under waitrequest
    end
  end

  assign clear_wr = local_sel & mm_write & reg_sel & lane_ok & ~stall_q;

  // write-one-to-clear mask, addressed lane only
  always_comb begin
    for (int i = 0; i < `FC_LANES; i++) begin
      if (clear_wr && int'(lane_idx) == i) begin
        lane_clear[i] = mm_writedata;  // ones clear
      end else begin
        lane_clear[i] = '0;
      end
    end
  end

endmodule

/* rtl/fc_lane.sv */
`include "fc_xcvr_config.svh"

module fc_lane (
  input  logic                       mgmt_clk,
  input  logic                       reset,
  input  fc_xcvr_pkg::char_word_t    tx_data,
  input  fc_xcvr_pkg::phy_word_t     rx_parallel_data,
  input  fc_xcvr_pkg::lane_flags_t   rx_datak,
  input  fc_xcvr_pkg::lane_flags_t   rx_syncstatus,
  input  fc_xcvr_pkg::lane_flags_t   rx_patterndetect,
  input  fc_xcvr_pkg::lane_flags_t   rx_errdetect,
  input  fc_xcvr_pkg::lane_flags_t   rx_disperr,
  input  logic                       pll_locked,
  input  fc_xcvr_pkg::mm_data_t      lane_clear,
  output fc_xcvr_pkg::phy_word_t     tx_parallel_data,
  output fc_xcvr_pkg::lane_flags_t   tx_datak,
  output fc_xcvr_pkg::char_word_t    rx_data,
  output logic                       rx_valid,
  output fc_xcvr_pkg::status_word_t  status_sync,
  output fc_xcvr_pkg::mm_data_t      sticky_errors
);

  import fc_xcvr_pkg::*;

  status_word_t status_raw;                   // phy side flags, unsynchronized
  status_word_t sync_q [`FC_SYNC_STAGES];     // synchronizer chain
  logic         full_sync;                    // all four sync bits, synchronized
  logic         full_sync_q;                  // full sync one cycle ago
  logic         pll_locked_q;                 // synchronized pll_locked one cycle ago
  sticky_word_t set_vec;                      // bits to set this cycle
  sticky_word_t sticky_q;

  // tx reorder
  // byte n of the char word goes to byte lane n of the phy word
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      tx_parallel_data[8*b +: 8] = tx_data[9*b +: 8];  // data byte
      tx_datak[b]                = tx_data[9*b + 8];   // k flag
    end
  end

  // rx rebuild, inverse of the tx rule
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      rx_data[9*b +: 8] = rx_parallel_data[8*b +: 8];
      rx_data[9*b + 8]  = rx_datak[b];
    end
  end

  assign rx_valid = rx_syncstatus == 4'b1111;  // word aligned on all bytes

  // status word as read back by software
  always_comb begin
    status_raw               = '0;
    status_raw.syncstatus    = rx_syncstatus;
    status_raw.patterndetect = rx_patterndetect;
    status_raw.errdetect     = rx_errdetect;
    status_raw.disperr       = rx_disperr;
    status_raw.pll_locked    = pll_locked;
  end

  // flags come from the phy recovered clock side
  always_ff @(posedge mgmt_clk) begin
    if (reset) begin
      for (int s = 0; s < `FC_SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= status_raw;
      for (int s = 1; s < `FC_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];  // shift one stage
      end
    end
  end

  assign status_sync = sync_q[`FC_SYNC_STAGES-1];
  assign full_sync   = status_sync.syncstatus == 4'b1111;

  // error events, all taken from the synchronized word
  always_comb begin
    set_vec           = '0;
    set_vec.disperr   = status_sync.disperr;
    set_vec.errdetect = status_sync.errdetect;
    set_vec.pll_lost  = pll_locked_q & ~status_sync.pll_locked;  // falling edge
    set_vec.sync_lost = full_sync_q & ~full_sync;                 // dropped out of sync
  end

  always_ff @(posedge mgmt_clk) begin
    if (reset) begin
      pll_locked_q <= 1'b0;
      full_sync_q  <= 1'b0;
      sticky_q     <= '0;
    end else begin
      pll_locked_q <= status_sync.pll_locked;
      full_sync_q  <= full_sync;
      // a flag still high during a clear keeps its bit
      sticky_q     <= (sticky_q & ~sticky_word_t'(lane_clear)) | set_vec;
    end
  end

  assign sticky_errors = mm_data_t'(sticky_q);

endmodule

/* rtl/fc_status_mux.sv */
`include "fc_xcvr_config.svh"

module fc_status_mux (
  input  fc_xcvr_pkg::status_word_t [`FC_LANES-1:0] status_sync,
  input  fc_xcvr_pkg::mm_data_t     [`FC_LANES-1:0] sticky_errors,
  input  fc_xcvr_pkg::mm_addr_t                     mm_address,
  input  logic                                      local_sel,
  input  fc_xcvr_pkg::mm_data_t                     phy_mgmt_readdata,
  output fc_xcvr_pkg::mm_data_t                     mm_readdata
);

  import fc_xcvr_pkg::*;

  localparam int idx_w = `FC_PHY_SEL_BIT - `FC_LANE_SEL_LSB;

  logic [idx_w-1:0]             lane_idx;   // whole lane field
  logic [`FC_LANE_SEL_BITS-1:0] lane_sel;   // bits that pick among lanes
  logic                         lane_ok;
  logic                         reg_sel;
  mm_data_t                     local_word;

  assign lane_idx = mm_address[`FC_PHY_SEL_BIT-1:`FC_LANE_SEL_LSB];
  assign lane_sel = lane_idx[`FC_LANE_SEL_BITS-1:0];
  assign lane_ok  = int'(lane_idx) < `FC_LANES;  // upper field bits count too
  assign reg_sel  = mm_address[`FC_REG_SEL_BIT];

  // local register file read
  always_comb begin
    local_word = '0;  // missing lanes read zero
    if (lane_ok) begin
      if (reg_sel) begin
        local_word = sticky_errors[lane_sel];
      end else begin
        local_word = mm_data_t'(status_sync[lane_sel]);
      end
    end
  end

  // phy readdata only on passthrough
  assign mm_readdata = local_sel ? local_word : phy_mgmt_readdata;

endmodule

/* rtl/fc_xcvr_array.sv */
`include "fc_xcvr_config.svh"

module fc_xcvr_array (
  input  logic                                       mgmt_clk,
  input  logic                                       reset,
  // management port
  input  fc_xcvr_pkg::mm_addr_t                      mm_address,
  input  logic                                       mm_read,
  input  logic                                       mm_write,
  input  fc_xcvr_pkg::mm_data_t                      mm_writedata,
  output fc_xcvr_pkg::mm_data_t                      mm_readdata,
  output logic                                       mm_waitrequest,
  // vendor phy management bus
  output fc_xcvr_pkg::phy_addr_t                     phy_mgmt_address,
  output logic                                       phy_mgmt_read,
  output logic                                       phy_mgmt_write,
  output fc_xcvr_pkg::mm_data_t                      phy_mgmt_writedata,
  input  fc_xcvr_pkg::mm_data_t                      phy_mgmt_readdata,
  input  logic                                       phy_mgmt_waitrequest,
  // user side, one word per lane
  input  fc_xcvr_pkg::char_word_t  [`FC_LANES-1:0]   tx_data,
  output fc_xcvr_pkg::char_word_t  [`FC_LANES-1:0]   rx_data,
  output logic                     [`FC_LANES-1:0]   rx_valid,
  // phy parallel side
  output fc_xcvr_pkg::phy_word_t   [`FC_LANES-1:0]   tx_parallel_data,
  output fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   tx_datak,
  input  fc_xcvr_pkg::phy_word_t   [`FC_LANES-1:0]   rx_parallel_data,
  input  fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   rx_datak,
  input  fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   rx_syncstatus,
  input  fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   rx_patterndetect,
  input  fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   rx_errdetect,
  input  fc_xcvr_pkg::lane_flags_t [`FC_LANES-1:0]   rx_disperr,
  input  logic                     [`FC_LANES-1:0]   pll_locked
);

  import fc_xcvr_pkg::*;

  logic                         local_sel;      // bit 9 clear
  mm_data_t     [`FC_LANES-1:0] lane_clear;     // per lane clear masks
  status_word_t [`FC_LANES-1:0] status_sync;    // live status, mgmt_clk side
  mm_data_t     [`FC_LANES-1:0] sticky_errors;

  fc_mgmt_decode decode_i (
    .mgmt_clk             (mgmt_clk),
    .reset                (reset),
    .mm_address           (mm_address),
    .mm_read              (mm_read),
    .mm_write             (mm_write),
    .mm_writedata         (mm_writedata),
    .phy_mgmt_waitrequest (phy_mgmt_waitrequest),
    .mm_waitrequest       (mm_waitrequest),
    .phy_mgmt_address     (phy_mgmt_address),
    .phy_mgmt_read        (phy_mgmt_read),
    .phy_mgmt_write       (phy_mgmt_write),
    .phy_mgmt_writedata   (phy_mgmt_writedata),
    .local_sel            (local_sel),
    .lane_clear           (lane_clear)
  );

  // identical lanes, each on its own slice
  for (genvar i = 0; i < `FC_LANES; i++) begin : g_lane
    fc_lane lane_i (
      .mgmt_clk         (mgmt_clk),
      .reset            (reset),
      .tx_data          (tx_data[i]),
      .rx_parallel_data (rx_parallel_data[i]),
      .rx_datak         (rx_datak[i]),
      .rx_syncstatus    (rx_syncstatus[i]),
      .rx_patterndetect (rx_patterndetect[i]),
      .rx_errdetect     (rx_errdetect[i]),
      .rx_disperr       (rx_disperr[i]),
      .pll_locked       (pll_locked[i]),
      .lane_clear       (lane_clear[i]),
      .tx_parallel_data (tx_parallel_data[i]),
      .tx_datak         (tx_datak[i]),
      .rx_data          (rx_data[i]),
      .rx_valid         (rx_valid[i]),
      .status_sync      (status_sync[i]),
      .sticky_errors    (sticky_errors[i])
    );
  end

  // read path back to the master
  fc_status_mux status_mux_i (
    .status_sync       (status_sync),
    .sticky_errors     (sticky_errors),
    .mm_address        (mm_address),
    .local_sel         (local_sel),
    .phy_mgmt_readdata (phy_mgmt_readdata),
    .mm_readdata       (mm_readdata)
  );

endmodule

/* tb/fc_clk_gen.sv */
module fc_clk_gen (
  output logic mgmt_clk,
  output logic reset
);

  localparam int half_period = 20;  // 40 time units per cycle
  localparam int reset_cycles = 4;

  initial begin
    mgmt_clk = 1'b0;
    forever begin
      #half_period mgmt_clk = ~mgmt_clk;
    end
  end

  // reset released on a rising edge, like any other input
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge mgmt_clk);
    reset <= 1'b0;
  end

endmodule

/* tb/fc_xcvr_tb.sv */
`include "fc_xcvr_config.svh"

module fc_xcvr_tb;

  import fc_xcvr_pkg::*;

  localparam int lanes = `FC_LANES;
  localparam int sw    = `FC_SYNC_STAGES;
  // rough length of all tests in cycles, doubled for the limit
  localparam int test_cycles = 2 * 2 * 16 + 4 * (sw + 2 + 2 * (lanes + 2))
                             + 10 * (sw + 4) + 12 * 2 * lanes + 16 * (7 + 3) + 40;
  localparam int run_limit = 2 * test_cycles + 200;

  logic                     mgmt_clk;
  logic                     reset;
  mm_addr_t                 mm_address;
  logic                     mm_read;
  logic                     mm_write;
  mm_data_t                 mm_writedata;
  mm_data_t                 mm_readdata;
  logic                     mm_waitrequest;
  phy_addr_t                phy_mgmt_address;
  logic                     phy_mgmt_read;
  logic                     phy_mgmt_write;
  mm_data_t                 phy_mgmt_writedata;
  mm_data_t                 phy_mgmt_readdata;
  logic                     phy_mgmt_waitrequest;
  char_word_t  [lanes-1:0]  tx_data;
  char_word_t  [lanes-1:0]  rx_data;
  logic        [lanes-1:0]  rx_valid;
  phy_word_t   [lanes-1:0]  tx_parallel_data;
  lane_flags_t [lanes-1:0]  tx_datak;
  phy_word_t   [lanes-1:0]  rx_parallel_data;
  lane_flags_t [lanes-1:0]  rx_datak;
  lane_flags_t [lanes-1:0]  rx_syncstatus;
  lane_flags_t [lanes-1:0]  rx_patterndetect;
  lane_flags_t [lanes-1:0]  rx_errdetect;
  lane_flags_t [lanes-1:0]  rx_disperr;
  logic        [lanes-1:0]  pll_locked;

  logic [31:0] lfsr;               // galois lfsr state
  int          errors;
  int          checks;
  int          cycles;
  mm_data_t    phy_mem [512];      // phy management register model
  mm_data_t    exp_sticky [lanes]; // expected sticky word per lane

  fc_clk_gen clk_gen_i (.mgmt_clk(mgmt_clk), .reset(reset));

  fc_xcvr_array dut_i (.*);

  // one lfsr step per bit taken
  function automatic logic [63:0] rnd(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic mm_addr_t reg_addr(input int lane, input bit sticky);
    return mm_addr_t'((lane << `FC_LANE_SEL_LSB) | (int'(sticky) << `FC_REG_SEL_BIT));
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic local_read(input mm_addr_t addr, output mm_data_t data);
    @(posedge mgmt_clk);
    mm_address <= addr;
    mm_read    <= 1'b1;
    @(negedge mgmt_clk);
    check(mm_waitrequest, 0, "local read stalled");
    check({phy_mgmt_read, phy_mgmt_write}, 0, "phy strobe on local read");
    data = mm_readdata;
    @(posedge mgmt_clk);
    mm_read <= 1'b0;
  endtask

  task automatic local_write(input mm_addr_t addr, input mm_data_t data);
    @(posedge mgmt_clk);
    mm_address   <= addr;
    mm_write     <= 1'b1;
    mm_writedata <= data;
    @(negedge mgmt_clk);
    check(mm_waitrequest, 0, "local write stalled");
    check({phy_mgmt_read, phy_mgmt_write}, 0, "phy strobe on local write");
    @(posedge mgmt_clk);
    mm_write <= 1'b0;  // clear lands on this edge
  endtask

  task automatic check_all_sticky(input string what);
    mm_data_t rd;
    for (int l = 0; l < lanes; l++) begin
      local_read(reg_addr(l, 1'b1), rd);
      check(rd, exp_sticky[l], $sformatf("%s, sticky lane %0d", what, l));
    end
  endtask

  task automatic tx_reorder_test;
    char_word_t d;
    for (int r = 0; r < 16; r++) begin
      @(posedge mgmt_clk);
      for (int l = 0; l < lanes; l++) tx_data[l] <= char_word_t'(rnd(36));
      @(negedge mgmt_clk);
      for (int l = 0; l < lanes; l++) begin
        d = tx_data[l];
        check(tx_parallel_data[l], {d[34:27], d[25:18], d[16:9], d[7:0]}, "tx data");
        check(tx_datak[l], {d[35], d[26], d[17], d[8]}, "tx datak");
      end
    end
  endtask

  task automatic rx_rebuild_test;
    phy_word_t   p;
    lane_flags_t k;
    for (int r = 0; r < 16; r++) begin
      @(posedge mgmt_clk);
      for (int l = 0; l < lanes; l++) begin
        rx_parallel_data[l] <= phy_word_t'(rnd(32));
        rx_datak[l]         <= lane_flags_t'(rnd(4));
        rx_syncstatus[l]    <= rnd(1) ? 4'hf : lane_flags_t'(rnd(4));  // full sync half the time
      end
      @(negedge mgmt_clk);
      for (int l = 0; l < lanes; l++) begin
        p = rx_parallel_data[l];
        k = rx_datak[l];
        check(rx_data[l], {k[3], p[31:24], k[2], p[23:16], k[1], p[15:8], k[0], p[7:0]},
              "rx data");
        check(rx_valid[l], rx_syncstatus[l] == 4'hf, "rx valid");
      end
    end
  endtask

  task automatic live_status_test;
    mm_data_t rd;
    for (int r = 0; r < 4; r++) begin
      @(posedge mgmt_clk);
      for (int l = 0; l < lanes; l++) begin
        rx_syncstatus[l]    <= lane_flags_t'(rnd(4));
        rx_patterndetect[l] <= lane_flags_t'(rnd(4));
        rx_errdetect[l]     <= lane_flags_t'(rnd(4));
        rx_disperr[l]       <= lane_flags_t'(rnd(4));
        pll_locked[l]       <= 1'(rnd(1));
      end
      repeat (sw + 1) @(posedge mgmt_clk);
      for (int l = 0; l < lanes; l++) begin
        local_read(reg_addr(l, 1'b0), rd);
        check(rd, {15'b0, pll_locked[l], rx_disperr[l], rx_errdetect[l],
                   rx_patterndetect[l], rx_syncstatus[l]}, $sformatf("status lane %0d", l));
      end
      local_read(reg_addr(lanes, 1'b0), rd);  // first missing lane
      check(rd, 0, "status of missing lane");
      local_read(reg_addr(63, 1'b1), rd);     // top of the lane field
      check(rd, 0, "sticky of missing lane");
    end
  endtask

  // quiet flags on every lane, then wipe all sticky bits
  task automatic settle_clean;
    @(posedge mgmt_clk);
    for (int l = 0; l < lanes; l++) begin
      rx_syncstatus[l]    <= 4'hf;
      rx_patterndetect[l] <= 4'h0;
      rx_errdetect[l]     <= 4'h0;
      rx_disperr[l]       <= 4'h0;
      pll_locked[l]       <= 1'b1;
    end
    repeat (sw + 3) @(posedge mgmt_clk);
    for (int l = 0; l < lanes; l++) begin
      local_write(reg_addr(l, 1'b1), 32'hffff_ffff);
      exp_sticky[l] = '0;
    end
    check_all_sticky("after clean");
  endtask

  task automatic sticky_test;
    int          a;
    int          b;
    lane_flags_t d;
    lane_flags_t e;
    mm_data_t    mask;
    settle_clean();
    a = int'(rnd(3)) % lanes;
    b = (a + 1) % lanes;  // same lane when only one exists
    d = lane_flags_t'(rnd(4));
    e = lane_flags_t'(rnd(4));
    @(posedge mgmt_clk);
    rx_disperr[a]   <= d;  // one cycle error pulse
    rx_errdetect[a] <= e;
    @(posedge mgmt_clk);
    rx_disperr[a]   <= 4'h0;
    rx_errdetect[a] <= 4'h0;
    exp_sticky[a] |= {24'b0, e, d};
    repeat (sw + 2) @(posedge mgmt_clk);
    check_all_sticky("error pulse");
    @(posedge mgmt_clk);
    pll_locked[b]    <= 1'b0;
    rx_syncstatus[a] <= 4'hf & ~(4'b1 << rnd(2));  // lose one byte's sync
    exp_sticky[b] |= 32'h100;
    exp_sticky[a] |= 32'h200;
    repeat (sw + 3) @(posedge mgmt_clk);
    check_all_sticky("pll and sync loss");
    @(posedge mgmt_clk);
    pll_locked[b]    <= 1'b1;  // recovery sets nothing
    rx_syncstatus[a] <= 4'hf;
    repeat (sw + 3) @(posedge mgmt_clk);
    check_all_sticky("after recovery");
    mask = mm_data_t'(rnd(10)) | 32'h100;  // bit 8 is also held by lane b
    local_write(reg_addr(a, 1'b1), mask);
    exp_sticky[a] &= ~mask;
    check_all_sticky("partial clear");
    local_write(reg_addr(b, 1'b1), 32'hffff_ffff);
    exp_sticky[b] = '0;
    check_all_sticky("full clear");
    @(posedge mgmt_clk);
    rx_disperr[a] <= 4'b0001;  // one cycle pulse
    @(posedge mgmt_clk);
    rx_disperr[a] <= 4'b0000;
    repeat (sw - 2) @(posedge mgmt_clk);
    local_write(reg_addr(a, 1'b1), 32'hffff_ffff);  // synced flag high on the clear edge only
    exp_sticky[a] = 32'h1;     // set wins over clear
    check_all_sticky("clear under live flag");
    @(posedge mgmt_clk);
    rx_disperr[a] <= 4'b0000;
    repeat (sw + 2) @(posedge mgmt_clk);
    local_write(reg_addr(a, 1'b1), 32'hffff_ffff);
    exp_sticky[a] = '0;
    check_all_sticky("final clear");
  endtask

  // phy slave model, stalls for a drawn number of cycles
  task automatic phy_access(input bit wr, input phy_addr_t a, input mm_data_t wdata,
                            input int stall);
    int       left;
    mm_data_t exp_rd;
    left   = stall;
    exp_rd = phy_mem[a];
    @(posedge mgmt_clk);
    mm_address           <= {1'b1, a};
    mm_read              <= ~wr;
    mm_write             <= wr;
    mm_writedata         <= wdata;
    phy_mgmt_waitrequest <= left > 0;
    phy_mgmt_readdata    <= exp_rd;
    while (1) begin
      @(negedge mgmt_clk);
      check(phy_mgmt_address, a, "phy address");
      check({phy_mgmt_read, phy_mgmt_write}, {~wr, wr}, "phy strobes");
      check(mm_waitrequest, left > 0, "waitrequest follows phy stall");
      if (wr) check(phy_mgmt_writedata, wdata, "phy writedata");
      if (left == 0) break;
      @(posedge mgmt_clk);
      left--;
      phy_mgmt_waitrequest <= left > 0;
    end
    if (wr) phy_mem[phy_mgmt_address] = phy_mgmt_writedata;  // slave takes the bus as seen
    else    check(mm_readdata, exp_rd, "phy readdata");
    @(posedge mgmt_clk);
    mm_read  <= 1'b0;
    mm_write <= 1'b0;
  endtask

  task automatic passthrough_test;
    phy_addr_t a;
    mm_data_t  wd;
    mm_data_t  rd;
    for (int r = 0; r < 8; r++) begin
      a  = phy_addr_t'(rnd(9));
      wd = mm_data_t'(rnd(32));
      phy_access(1'b0, a, '0, int'(rnd(3)));  // fill pattern first
      phy_access(1'b1, a, wd, int'(rnd(3)));
      phy_access(1'b0, a, '0, int'(rnd(3)));  // reads back the write
      local_read(reg_addr(0, 1'b0), rd);      // checks no phy strobe
      check(rd, {15'b0, pll_locked[0], rx_disperr[0], rx_errdetect[0],
                 rx_patterndetect[0], rx_syncstatus[0]}, "local read beside phy data");
    end
  endtask

  // hard limit on run length
  always @(posedge mgmt_clk) begin
    cycles <= cycles + 1;
    if (cycles >= run_limit) begin
      $display("timeout: run did not finish within %0d cycles", run_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    lfsr         = 32'h4389_3795;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    mm_address   = '0;
    mm_read      = 1'b0;
    mm_write     = 1'b0;
    mm_writedata = '0;
    phy_mgmt_readdata    = '0;
    phy_mgmt_waitrequest = 1'b0;
    tx_data          = '0;
    rx_parallel_data = '0;
    rx_datak         = '0;
    rx_syncstatus    = '0;
    rx_patterndetect = '0;
    rx_errdetect     = '0;
    rx_disperr       = '0;
    pll_locked       = '0;
    for (int i = 0; i < 512; i++) begin
      phy_mem[i] = {7'h5a, 9'(i), 7'h25, ~9'(i)};  // whole address in the pattern
    end
    while (reset !== 1'b0) @(posedge mgmt_clk);
    @(negedge mgmt_clk);
    check({phy_mgmt_read, phy_mgmt_write}, 0, "phy strobes after reset");
    tx_reorder_test();
    rx_rebuild_test();
    live_status_test();
    sticky_test();
    passthrough_test();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* fc_xcvr_array.f */
+incdir+include
rtl/fc_xcvr_pkg.sv
rtl/fc_mgmt_decode.sv
rtl/fc_lane.sv
rtl/fc_status_mux.sv
rtl/fc_xcvr_array.sv
tb/fc_clk_gen.sv
tb/fc_xcvr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fc_xcvr_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
fail_msg='*** TEST FAILED ***'

verilator --binary --timing -j 0 \
  --top-module fc_xcvr_tb \
  -f fc_xcvr_array.f \
  -o fc_xcvr_sim > build.log 2>&1 \
  && ./obj_dir/fc_xcvr_sim > "$log" 2>&1 \
  || { cat build.log "$log" 2>/dev/null; echo "build or run did not complete"; exit 1; }

cat "$log"
grep -qF "$fail_msg" "$log" \
  && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }
